// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wall
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        ?= hisBuilderTb
FILELIST   ?= tb.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== src/hisBuilderTop.sv ====
`timescale 1ns/1ps

module hisBuilderTop (
    input  logic               clk,
    input  logic               reset,
    input  logic               wrEn,
    input  sensorPkg::sample_t data,
    input  logic               histEnable,
    input  logic               histClear,
    input  histPkg::binIdx_t   binSel,
    output histPkg::binCount_t binCount,
    output logic               overflow,
    output logic               histIdle
);
    import sensorPkg::*;

    logic       wordValid;
    pixelWord_t word;
    pixelWord_t headWord;
    logic       notEmpty;
    logic       pop;
    logic       binnerIdle;

    // ----------------------------------------------------------------------
    // producer, buffer and consumer
    // ----------------------------------------------------------------------

    pixelAssembler assembler_i (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .data      (data),
        .wordValid (wordValid),
        .word      (word)
    );

    pixelWordFifo fifo_i (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wordValid),
        .wrWord   (word),
        .pop      (pop),
        .headWord (headWord),
        .notEmpty (notEmpty),
        .overflow (overflow)
    );

    histogramBinner binner_i (
        .clk        (clk),
        .reset      (reset),
        .notEmpty   (notEmpty),
        .headWord   (headWord),
        .histEnable (histEnable),
        .histClear  (histClear),
        .binSel     (binSel),
        .pop        (pop),
        .binCount   (binCount),
        .idle       (binnerIdle)
    );

    assign histIdle = binnerIdle && !notEmpty;  // nothing left to bin anywhere.

endmodule

// ==== src/histPkg.sv ====
package histPkg;

    // ----------------------------------------------------------------------
    // histogram geometry
    // ----------------------------------------------------------------------

    localparam int BIN_W = 4;             // a bin is picked by the top pixel bits.
    localparam int NUM_BINS = 1 << BIN_W;
    localparam int COUNT_W = 16;          // counters wrap at this width.

    // ----------------------------------------------------------------------
    // word buffer between the assembler and the binner
    // ----------------------------------------------------------------------

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [BIN_W-1:0] binIdx_t;
    typedef logic [COUNT_W-1:0] binCount_t;

    // The binner spends one cycle per pixel after leaving IDLE.
    typedef enum logic [1:0] {
        IDLE,
        PIX0,
        PIX1,
        PIX2
    } binState_t;

endpackage

// ==== src/histogramBinner.sv ====
`timescale 1ns/1ps

module histogramBinner (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  notEmpty,
    input  sensorPkg::pixelWord_t headWord,
    input  logic                  histEnable,
    input  logic                  histClear,
    input  histPkg::binIdx_t      binSel,
    output logic                  pop,
    output histPkg::binCount_t    binCount,
    output logic                  idle
);
    import sensorPkg::*;
    import histPkg::*;

    binState_t  state;
    pixelWord_t wordReg;                 // word being binned, taken at the pop.
    pixel_t     curPixel;
    binIdx_t    curBin;
    binCount_t  counts [NUM_BINS];

    // The bin is the top BIN_W bits of the pixel.
    function automatic binIdx_t topBin(input pixel_t p);
        return binIdx_t'(p >> (PIXEL_W - BIN_W));
    endfunction

    assign pop = (state == IDLE) && notEmpty && histEnable;
    assign idle = (state == IDLE);

    // ----------------------------------------------------------------------
    // word walk
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= PIX0;
                    end
                end
                PIX0:    state <= PIX1;
                PIX1:    state <= PIX2;
                default: state <= IDLE;  // PIX2 finishes the word.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wordReg <= headWord;
        end
    end

    // pixels are visited in time order, one per cycle.
    always_comb begin
        case (state)
            PIX0:    curPixel = wordReg.pix0;
            PIX1:    curPixel = wordReg.pix1;
            default: curPixel = wordReg.pix2;
        endcase
    end

    assign curBin = topBin(curPixel);

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------

    // A clear on the same edge as an increment wins, so that increment is lost.
    always_ff @(posedge clk) begin
        if (reset || histClear) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                counts[i] <= '0;
            end
        end else if (state != IDLE) begin
            counts[curBin] <= counts[curBin] + 1'b1;  // wraps at full scale.
        end
    end

    assign binCount = counts[binSel];  // host readout has no latency.

endmodule

// ==== src/pixelAssembler.sv ====
`timescale 1ns/1ps

module pixelAssembler (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wrEn,
    input  sensorPkg::sample_t   data,
    output logic                 wordValid,
    output sensorPkg::pixelWord_t word
);
    import sensorPkg::*;

    typedef enum logic {
        FIRST,
        SECOND
    } pairState_t;

    pairState_t        state;
    logic [SLOT_W-1:0] slot;        // which pix field the next pixel goes into.
    sample_t           firstSample; // held until its partner arrives.
    logic [SAMPLE_W:0] sum;
    pixel_t            pixel;
    pixelWord_t        wordReg;

    // ----------------------------------------------------------------------
    // pixel value
    // ----------------------------------------------------------------------

    // The sum needs one extra bit so that two full-scale samples do not wrap.
    assign sum = {1'b0, firstSample} + {1'b0, data};
    assign pixel = pixel_t'(sum >> 1);  // dropping the low bit gives the floor of the mean.

    // ----------------------------------------------------------------------
    // pairing and slot control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FIRST;
            slot <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;  // strobe lasts a single cycle.
            if (wrEn) begin
                case (state)
                    FIRST: begin
                        state <= SECOND;
                    end
                    default: begin
                        state <= FIRST;
                        if (slot == SLOT_W'(PIXELS_PER_WORD - 1)) begin
                            slot <= '0;
                            wordValid <= 1'b1;  // the word is complete after this edge.
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // payload
    // ----------------------------------------------------------------------

    // The next pix0 can only land two samples after the strobe, so the word
    // stays stable while the buffer takes it.
    always_ff @(posedge clk) begin
        if (wrEn && state == FIRST) begin
            firstSample <= data;
        end
        if (wrEn && state == SECOND) begin
            case (slot)
                SLOT_W'(0): wordReg.pix0 <= pixel;
                SLOT_W'(1): wordReg.pix1 <= pixel;
                default:    wordReg.pix2 <= pixel;
            endcase
        end
    end

    assign word = wordReg;

endmodule

// ==== src/pixelWordFifo.sv ====
`timescale 1ns/1ps

module pixelWordFifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wrEn,
    input  sensorPkg::pixelWord_t wrWord,
    input  logic                  pop,
    output sensorPkg::pixelWord_t headWord,
    output logic                  notEmpty,
    output logic                  overflow
);
    import sensorPkg::*;
    import histPkg::*;

    pixelWord_t          mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [FIFO_CNT_W-1:0] count;   // words currently held.
    logic                  full;
    logic                  doWrite;
    logic                  doPop;

    assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign notEmpty = (count != '0);
    assign doWrite = wrEn && !full;  // a write into a full buffer is lost.
    assign doPop = pop && notEmpty;

    // head is read straight from the array, so it falls through with no latency.
    assign headWord = mem[rdPtr];

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrWord;
        end
    end

    // ----------------------------------------------------------------------
    // pointers, occupancy and overflow
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the level unchanged.
            endcase
            if (wrEn && full) begin
                overflow <= 1'b1;  // sticky until the next reset.
            end
        end
    end

endmodule

// ==== src/sensorPkg.sv ====
package sensorPkg;

    // ----------------------------------------------------------------------
    // sample and pixel widths
    // ----------------------------------------------------------------------

    localparam int SAMPLE_W = 10;        // width of one raw detector sample.
    localparam int PIXEL_W = SAMPLE_W;   // the mean of two samples keeps the sample width.

    // ----------------------------------------------------------------------
    // pixel packing into one RAM word
    // ----------------------------------------------------------------------

    localparam int PIXELS_PER_WORD = 3;
    localparam int SLOT_W = $clog2(PIXELS_PER_WORD);  // slot counter width in the assembler.

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [PIXEL_W-1:0] pixel_t;

    // pix0 sits in the low bits, as the readout side expects.
    typedef struct packed {
        pixel_t pix2;   // last pixel in time.
        pixel_t pix1;
        pixel_t pix0;   // first pixel in time.
    } pixelWord_t;

endpackage

// ==== tb.f ====
src/sensorPkg.sv
src/histPkg.sv
src/pixelAssembler.sv
src/pixelWordFifo.sv
src/histogramBinner.sv
src/hisBuilderTop.sv
tests/hisBuilder_sva.sv
tests/hisBuilderTb.sv

// ==== tests/hisBuilderTb.sv ====
`timescale 1ns/1ps

module hisBuilderTb;
    import sensorPkg::*;
    import histPkg::*;

    localparam int CLK_HALF = 10;          // half of the 20 ns clock period.
    localparam int RESET_CYCLES = 3;
    localparam int RAND_SAMPLES = 600;
    localparam int BLOCKED_WORDS = 8;      // twice what the buffer can hold.
    localparam int DIRECTED_SAMPLES = 12;
    localparam int SHORT_SAMPLES = 6;
    localparam int IDLE_LIMIT = 64;        // longest drain we accept, in cycles.
    localparam int SWEEPS = 6;             // full bin readouts over the run.

    // Each sample costs at most three cycles, each bin read one, each drain its limit.
    localparam int STIM_CYCLES = RESET_CYCLES + 2 * RAND_SAMPLES
        + 3 * (DIRECTED_SAMPLES + SHORT_SAMPLES)
        + 2 * PIXELS_PER_WORD * BLOCKED_WORDS + SWEEPS * (NUM_BINS + IDLE_LIMIT + 8);

    localparam sample_t DIRECTED [DIRECTED_SAMPLES] = '{
        10'd108, 10'd511, 10'd1022, 10'd200, 10'd90, 10'd1023,
        10'd1023, 10'd1023, 10'd0, 10'd1, 10'd511, 10'd512
    };
    localparam sample_t SHORT [SHORT_SAMPLES] = '{
        10'd5, 10'd700, 10'd300, 10'd301, 10'd1023, 10'd0
    };

    logic      clk;
    logic      reset;
    logic      wrEn;
    sample_t   data;
    logic      histEnable;
    logic      histClear;
    binIdx_t   binSel;
    binCount_t binCount;
    logic      overflow;
    logic      histIdle;

    // ----------------------------------------------------------------------
    // reference model state
    // ----------------------------------------------------------------------

    logic [31:0] lfsr;
    binCount_t   expCount [NUM_BINS];
    sample_t     heldSample;      // first sample of a pair still waiting.
    logic        haveHeld;
    pixel_t      pixQueue [$];    // pixels of the word being filled.
    int          heldWords;       // words parked in the buffer while popping is off.
    int          pixelsCounted;   // pixels that must show up in the bins.

    hisBuilderTop dut_i (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .data       (data),
        .histEnable (histEnable),
        .histClear  (histClear),
        .binSel     (binSel),
        .binCount   (binCount),
        .overflow   (overflow),
        .histIdle   (histIdle)
    );

    bind hisBuilderTop hisBuilderSva sva_i (
        .clk       (clk),
        .reset     (reset),
        .histClear (histClear),
        .binCount  (binCount),
        .overflow  (overflow),
        .histIdle  (histIdle)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    function automatic logic nextLfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32, 22, 2 and 1.
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextLfsrBit()};
        end
        return v;
    endfunction

    task automatic reportError(input string msg);
        $display("** Error [%0t] %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic driveSlot();
        @(posedge clk);
        #1;  // inputs change well clear of the edge.
    endtask

    task automatic modelWord();
        pixel_t  p;
        binIdx_t idx;
        if (!histEnable) begin
            if (heldWords == FIFO_DEPTH) begin
                pixQueue.delete();  // a full buffer drops the word.
                return;
            end
            heldWords++;
        end
        while (pixQueue.size() > 0) begin
            p = pixQueue.pop_front();
            idx = p[PIXEL_W-1 -: BIN_W];
            expCount[idx] = expCount[idx] + binCount_t'(1);
            pixelsCounted++;
        end
    endtask

    task automatic modelSample(input sample_t s);
        if (!haveHeld) begin
            heldSample = s;
            haveHeld = 1'b1;
        end else begin
            haveHeld = 1'b0;
            pixQueue.push_back(pixel_t'((int'(heldSample) + int'(s)) / 2));
            if (pixQueue.size() == PIXELS_PER_WORD) begin
                modelWord();
            end
        end
    endtask

    task automatic sendSample(input sample_t s, input int gap);
        driveSlot();
        wrEn = 1'b1;
        data = s;
        modelSample(s);
        repeat (gap) begin
            driveSlot();
            wrEn = 1'b0;
        end
    endtask

    task automatic waitIdle();
        int waited;
        driveSlot();
        wrEn = 1'b0;
        repeat (3) @(posedge clk);  // the last word takes two edges to reach the buffer.
        waited = 0;
        @(negedge clk);
        while (!histIdle) begin
            waited++;
            if (waited > IDLE_LIMIT) begin
                $display("histIdle did not come back within %0d cycles", IDLE_LIMIT);
                $display("=== FAIL ===");
                $fatal(1, "histogram never drained");
            end
            @(negedge clk);
        end
    endtask

    task automatic readBin(input binIdx_t idx, output binCount_t value);
        driveSlot();
        binSel = idx;
        @(negedge clk);
        value = binCount;
    endtask

    task automatic checkBins(input string tag);
        binCount_t got [NUM_BINS];
        int        total;
        total = 0;
        for (int i = 0; i < NUM_BINS; i++) begin
            readBin(binIdx_t'(i), got[i]);
            total += int'(got[i]);
        end
        // a lost or doubled increment shows in the total, whatever bin it hit.
        assert (total == pixelsCounted)
            else reportError($sformatf("%s: bins sum to %0d, expected %0d",
                                       tag, total, pixelsCounted));
        for (int i = 0; i < NUM_BINS; i++) begin
            assert (got[i] == expCount[i])
                else reportError($sformatf("%s: bin %0d is %0d, expected %0d",
                                           tag, i, got[i], expCount[i]));
        end
    endtask

    task automatic checkFlags(input string tag, input logic expIdle, input logic expOvf);
        @(negedge clk);
        assert (histIdle == expIdle)
            else reportError($sformatf("%s: histIdle is %b, expected %b", tag, histIdle, expIdle));
        assert (overflow == expOvf)
            else reportError($sformatf("%s: overflow is %b, expected %b", tag, overflow, expOvf));
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial begin
        sample_t s;
        int      gap;
        reset = 1'b1;
        wrEn = 1'b0;
        data = '0;
        histEnable = 1'b1;
        histClear = 1'b0;
        binSel = '0;
        lfsr = 32'h2f9c020f;
        heldSample = '0;
        haveHeld = 1'b0;
        heldWords = 0;
        pixelsCounted = 0;
        for (int i = 0; i < NUM_BINS; i++) begin
            expCount[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        checkFlags("after reset", 1'b1, 1'b0);
        checkBins("after reset");

        for (int i = 0; i < DIRECTED_SAMPLES; i++) begin
            sendSample(DIRECTED[i], (i % 2 == 0) ? 2 : 0);  // gaps fall inside pairs.
        end
        waitIdle();
        checkBins("directed");

        for (int i = 0; i < RAND_SAMPLES; i++) begin
            s = sample_t'(randomBits(SAMPLE_W));
            gap = int'(randomBits(1));
            sendSample(s, gap);
        end
        waitIdle();
        checkFlags("random stream", 1'b1, 1'b0);
        checkBins("random stream");

        driveSlot();
        histEnable = 1'b0;  // the buffer now fills and then drops words.
        for (int i = 0; i < 2 * PIXELS_PER_WORD * BLOCKED_WORDS; i++) begin
            s = sample_t'(randomBits(SAMPLE_W));
            sendSample(s, 0);
        end
        driveSlot();
        wrEn = 1'b0;
        repeat (3) @(posedge clk);
        checkFlags("blocked", 1'b0, 1'b1);
        driveSlot();
        histEnable = 1'b1;
        heldWords = 0;
        waitIdle();
        checkBins("after overflow");

        driveSlot();
        histClear = 1'b1;
        driveSlot();
        histClear = 1'b0;
        pixelsCounted = 0;
        for (int i = 0; i < NUM_BINS; i++) begin
            expCount[i] = '0;
        end
        checkBins("after clear");
        for (int i = 0; i < SHORT_SAMPLES; i++) begin
            sendSample(SHORT[i], (i % 2 == 0) ? 1 : 0);
        end
        waitIdle();
        checkBins("after clear stream");

        if (dut_i.sva_i.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------

    initial begin
        repeat (STIM_CYCLES + 200) @(posedge clk);
        $display("watchdog: the run went past its cycle budget and was stopped");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tests/hisBuilder_sva.sv ====
`timescale 1ns/1ps

module hisBuilderSva (
    input logic               clk,
    input logic               reset,
    input logic               histClear,
    input histPkg::binCount_t binCount,
    input logic               overflow,
    input logic               histIdle
);

    int failCount = 0;  // read by the testbench at the end of the run.

    // ----------------------------------------------------------------------
    // properties on the top-level ports
    // ----------------------------------------------------------------------

    // once a word has been dropped the flag holds until reset.
    property overflowSticky;
        @(posedge clk) disable iff (reset)
            overflow |=> overflow;
    endproperty

    // a clear leaves every counter at zero, whichever one is selected.
    property clearZeros;
        @(posedge clk) disable iff (reset)
            histClear |=> (binCount == '0);
    endproperty

    property idleAfterReset;
        @(posedge clk)
            $fell(reset) |-> histIdle;
    endproperty

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------

    overflowHeld: assert property (overflowSticky)
        else begin
            failCount++;
            $error("overflow fell while reset was low");
        end

    clearedCounts: assert property (clearZeros)
        else begin
            failCount++;
            $error("binCount is not zero in the cycle after histClear");
        end

    idleOnStart: assert property (idleAfterReset)
        else begin
            failCount++;
            $error("histIdle is low in the first cycle after reset");
        end

endmodule
